//--- spinn_link_consts.svh
`ifndef SPINN_LINK_CONSTS_SVH
`define SPINN_LINK_CONSTS_SVH

// packet geometry
`define PKT_BITS      72   // full long packet
`define SHORT_SYMS    10   // nibbles in a short packet
`define LONG_SYMS     18   // nibbles in a long packet
`define LONG_FLAG_BIT 1    // set means long packet

`define SYNC_STAGES   2    // ack synchronizer flops

// NRZ 2-of-7 toggle patterns, two bits set in each
`define CODE_0   7'b0010001
`define CODE_1   7'b0010010
`define CODE_2   7'b0010100
`define CODE_3   7'b0011000
`define CODE_4   7'b0100001
`define CODE_5   7'b0100010
`define CODE_6   7'b0100100
`define CODE_7   7'b0101000
`define CODE_8   7'b1000001
`define CODE_9   7'b1000010
`define CODE_10  7'b1000100
`define CODE_11  7'b1001000
`define CODE_12  7'b0000011
`define CODE_13  7'b0000110
`define CODE_14  7'b0001100
`define CODE_15  7'b0001001
`define CODE_EOP 7'b1100000  // end of packet

`endif

//--- spinn_link_pkg.sv
`default_nettype none

`include "spinn_link_consts.svh"

package spinn_link_pkg;

  // ------------------------------------------------------------------------
  // vector types
  // ------------------------------------------------------------------------
  typedef logic [`PKT_BITS-1:0] pkt_t;        // whole packet, long flag at bit 1

  typedef logic [3:0]           nibble_t;     // one payload symbol

  typedef logic [4:0]           symbol_t;     // {eop, nibble}

  typedef logic [6:0]           link_data_t;  // state of the seven link wires

  typedef logic [4:0]           sym_cnt_t;    // up to 18 nibbles

  // ------------------------------------------------------------------------
  // serializer FSM
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    ser_idle,      // waiting for a packet
    ser_park,      // packet held, eop still on its way out
    ser_transmit   // shifting nibbles out
  } ser_state_t;

endpackage

`default_nettype wire

//--- nrz_2of7_encoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "spinn_link_consts.svh"

module nrz_2of7_encoder
  import spinn_link_pkg::*;
(
  input  symbol_t    sym,   // bit 4 is eop
  input  link_data_t prev,  // current wire state
  output link_data_t code   // next wire state
);

  nibble_t    nib;
  link_data_t pattern;  // wires to toggle

  assign nib = sym[3:0];

  // symbol to toggle pattern
  always_comb begin
    case (nib)
      4'h0: pattern = `CODE_0;
      4'h1: pattern = `CODE_1;
      4'h2: pattern = `CODE_2;
      4'h3: pattern = `CODE_3;
      4'h4: pattern = `CODE_4;
      4'h5: pattern = `CODE_5;
      4'h6: pattern = `CODE_6;
      4'h7: pattern = `CODE_7;
      4'h8: pattern = `CODE_8;
      4'h9: pattern = `CODE_9;
      4'ha: pattern = `CODE_10;
      4'hb: pattern = `CODE_11;
      4'hc: pattern = `CODE_12;
      4'hd: pattern = `CODE_13;
      4'he: pattern = `CODE_14;
      default: pattern = `CODE_15;
    endcase
    if (sym[4]) begin
      pattern = `CODE_EOP;  // nibble ignored for eop
    end
  end

  // NRZ, so the pattern flips two wires of the old state
  assign code = prev ^ pattern;

endmodule

`default_nettype wire

//--- pkt_serializer.sv
`timescale 1ns/100ps
`default_nettype none

`include "spinn_link_consts.svh"

module pkt_serializer
  import spinn_link_pkg::*;
(
  input  logic       CLK_IN,
  input  logic       RESET_IN,

  // packet side
  input  pkt_t       pkt_data,
  input  logic       pkt_vld,
  output logic       pkt_rdy,

  // symbol side, already encoded as next wire state
  output link_data_t flt_data,
  output logic       flt_vld,
  input  logic       flt_rdy
);

  // --------------------------------------------------------------------------
  // internal signals
  // --------------------------------------------------------------------------
  ser_state_t state;

  pkt_t       pkt_buf;    // nibbles still to go
  logic       pkt_long;   // latched long flag
  sym_cnt_t   sym_cnt;    // nibbles loaded into flt_data so far

  logic       pkt_acpt;   // packet taken this cycle
  logic       flt_busy;   // symbol waiting on the link stage
  logic       eop;        // all nibbles loaded

  nibble_t    next_nib;
  symbol_t    next_sym;
  link_data_t next_code;

  assign pkt_acpt = pkt_vld && pkt_rdy;
  assign flt_busy = flt_vld && !flt_rdy;

  assign eop = (!pkt_long && (sym_cnt == sym_cnt_t'(`SHORT_SYMS)))
             || (sym_cnt == sym_cnt_t'(`LONG_SYMS));

  // --------------------------------------------------------------------------
  // next symbol, straight from the input when idle
  // --------------------------------------------------------------------------
  always_comb begin
    if (state == ser_idle) begin
      next_nib = pkt_data[3:0];     // first nibble
      next_sym = {1'b0, next_nib};
    end else begin
      next_nib = pkt_buf[3:0];      // next nibble, or first one after park
      next_sym = {eop, next_nib};
    end
  end

  nrz_2of7_encoder enc0 (
    .sym  (next_sym),
    .prev (flt_data),   // own register holds the wire state to come
    .code (next_code)
  );

  // packet handshake
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_rdy <= 1'b0;
    end else begin
      case (state)
        ser_idle:     pkt_rdy <= !pkt_acpt;         // closes once one is taken
        ser_transmit: pkt_rdy <= eop && !flt_busy;  // eop loaded, open again
        default:      pkt_rdy <= 1'b0;              // parked
      endcase
    end
  end

  // packet buffer, one nibble gone per load
  always_ff @(posedge CLK_IN) begin
    case (state)
      ser_idle: begin
        if (pkt_acpt) begin
          if (flt_busy) begin
            pkt_buf <= pkt_data;       // park whole packet
          end else begin
            pkt_buf <= pkt_data >> 4;  // first nibble encoded now
          end
        end
      end
      default: begin
        if (!flt_busy) begin
          pkt_buf <= pkt_buf >> 4;
        end
      end
    endcase
  end

  always_ff @(posedge CLK_IN) begin
    if ((state == ser_idle) && pkt_acpt) begin
      pkt_long <= pkt_data[`LONG_FLAG_BIT];
    end
  end

  // --------------------------------------------------------------------------
  // symbol side
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_data <= '0;  // matches idle link wires
    end else if (state == ser_idle) begin
      if (pkt_acpt && !flt_busy) begin
        flt_data <= next_code;
      end
    end else if (!flt_busy) begin
      flt_data <= next_code;  // nibble or eop
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_vld <= 1'b0;
    end else if (state == ser_idle) begin
      if (!flt_busy) begin
        flt_vld <= pkt_acpt;  // drops after eop leaves
      end
    end else begin
      flt_vld <= 1'b1;        // always a symbol ready mid-packet
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      sym_cnt <= sym_cnt_t'(1);
    end else if (state != ser_transmit) begin
      sym_cnt <= sym_cnt_t'(1);     // first nibble counts once loaded
    end else if (!flt_busy) begin
      sym_cnt <= sym_cnt + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= ser_idle;
    end else begin
      case (state)
        ser_idle: begin
          if (pkt_acpt && flt_busy) begin
            state <= ser_park;      // previous eop still out
          end else if (pkt_acpt) begin
            state <= ser_transmit;
          end
        end
        ser_park: begin
          if (!flt_busy) begin
            state <= ser_transmit;
          end
        end
        default: begin
          if (eop && !flt_busy) begin
            state <= ser_idle;      // eop loaded, packet done here
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- flit_link_tx.sv
`timescale 1ns/100ps
`default_nettype none

`include "spinn_link_consts.svh"

module flit_link_tx
  import spinn_link_pkg::*;
(
  input  logic       CLK_IN,
  input  logic       RESET_IN,

  // from serializer
  input  link_data_t flt_data,
  input  logic       flt_vld,
  output logic       flt_rdy,

  // link wires
  output link_data_t sl_data,
  input  logic       sl_ack    // async, one toggle per symbol
);

  // --------------------------------------------------------------------------
  // internal signals
  // --------------------------------------------------------------------------
  logic [`SYNC_STAGES-1:0] ack_sync;  // synchronizer chain

  logic ack_now;    // synchronized ack
  logic ack_prev;   // ack one cycle back
  logic acked;      // toggle seen
  logic sym_out;    // symbol on the wires, no ack yet
  logic xfer;       // symbol taken this cycle

  // --------------------------------------------------------------------------
  // ack synchronizer and toggle detect
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      ack_sync <= '0;
    end else begin
      ack_sync <= {ack_sync[`SYNC_STAGES-2:0], sl_ack};
    end
  end

  assign ack_now = ack_sync[`SYNC_STAGES-1];

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      ack_prev <= 1'b0;  // receiver ack wire idles low
    end else begin
      ack_prev <= ack_now;
    end
  end

  assign acked = ack_now ^ ack_prev;

  // --------------------------------------------------------------------------
  // one symbol outstanding at most
  // --------------------------------------------------------------------------
  assign xfer = flt_vld && flt_rdy;

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      sym_out <= 1'b0;
    end else if (xfer) begin
      sym_out <= 1'b1;      // wires change this edge
    end else if (acked) begin
      sym_out <= 1'b0;      // only clears what is pending
    end
  end

  // stray toggle with nothing pending just falls through above

  assign flt_rdy = !sym_out;

  // --------------------------------------------------------------------------
  // wire register
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      sl_data <= '0;
    end else if (xfer) begin
      sl_data <= flt_data;  // already XORed onto old state
    end
  end

endmodule

`default_nettype wire

//--- spinn_link_sender.sv
`timescale 1ns/100ps
`default_nettype none

module spinn_link_sender
  import spinn_link_pkg::*;
(
  input  logic       CLK_IN,
  input  logic       RESET_IN,

  // packet side, valid/ready
  input  pkt_t       pkt_data,
  input  logic       pkt_vld,
  output logic       pkt_rdy,

  // SpiNNaker link
  output link_data_t sl_data,   // NRZ 2-of-7 wires
  input  logic       sl_ack     // async ack from far end
);

  // --------------------------------------------------------------------------
  // serializer to link stage
  // --------------------------------------------------------------------------
  link_data_t flt_data;   // encoded next wire state
  logic       flt_vld;
  logic       flt_rdy;    // high when nothing outstanding

  pkt_serializer ser0 (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .flt_data (flt_data),
    .flt_vld  (flt_vld),
    .flt_rdy  (flt_rdy)
  );

  flit_link_tx tx0 (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .flt_data (flt_data),
    .flt_vld  (flt_vld),
    .flt_rdy  (flt_rdy),
    .sl_data  (sl_data),
    .sl_ack   (sl_ack)
  );

endmodule

`default_nettype wire

//--- spinn_link_sva.sv
`timescale 1ns/100ps
`default_nettype none

module spinn_link_sva
  import spinn_link_pkg::*;
(
  input logic       CLK_IN,
  input logic       RESET_IN,
  input link_data_t flt_data,
  input logic       flt_vld,
  input logic       flt_rdy,
  input link_data_t sl_data,
  input logic       sl_ack    // far end ack wire
);

  link_data_t wires_q;  // sl_data one edge back
  logic       ack_q;    // sl_ack one edge back
  logic       owed;     // wires moved, no ack toggle since

  // ----------------------------------------------------------------------------
  // symbol owed to the far end, seen from the wires only
  // ----------------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      wires_q <= '0;
      ack_q   <= 1'b0;
      owed    <= 1'b0;
    end else begin
      wires_q <= sl_data;
      ack_q   <= sl_ack;
      if (sl_data != wires_q) begin
        owed <= 1'b1;
      end else if (sl_ack != ack_q) begin
        owed <= 1'b0;   // far end took it
      end
    end
  end

  // ----------------------------------------------------------------------------
  // link wire protocol
  // ----------------------------------------------------------------------------
  two_wires_flip: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (sl_data != $past(sl_data)) |-> ($countones(sl_data ^ $past(sl_data)) == 2))
    else $error("sl_data changed in other than two wires");

  // one symbol per ack
  wires_held: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (sl_data != wires_q) |-> !owed)
    else $error("sl_data moved again before the ack toggle");

  flit_held: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (flt_vld && !flt_rdy) |=> $stable(flt_data))
    else $error("flt_data moved while stalled");

endmodule

bind flit_link_tx spinn_link_sva sva0 (
  .CLK_IN   (CLK_IN),
  .RESET_IN (RESET_IN),
  .flt_data (flt_data),
  .flt_vld  (flt_vld),
  .flt_rdy  (flt_rdy),
  .sl_data  (sl_data),
  .sl_ack   (sl_ack)
);

`default_nettype wire

//--- tb_link_receiver.sv
`timescale 1ns/100ps
`default_nettype none

`include "spinn_link_consts.svh"

module tb_link_receiver
  import spinn_link_pkg::*;
(
  input  logic       CLK_IN,
  input  logic       RESET_IN,
  input  link_data_t sl_data,
  input  logic [3:0] ack_delay,  // cycles before the ack toggle
  output logic       sl_ack,
  output pkt_t       rx_pkt,     // last finished packet
  output int         rx_nsyms,   // its nibble count
  output int         rx_count,   // packets finished so far
  output logic       rx_bad      // sticky protocol error
);

  link_data_t last_data;  // wire state already decoded
  logic [5:0] dec;        // {bad, eop, nibble}
  logic       pend;       // ack still owed
  logic [3:0] wait_cnt;
  logic       ack_tgl = 1'b0;
  pkt_t       rx_buf;
  int         nib_idx;

  function automatic logic [5:0] decode_sym(input link_data_t pat);
    case (pat)
      `CODE_0:   decode_sym = 6'h00;
      `CODE_1:   decode_sym = 6'h01;
      `CODE_2:   decode_sym = 6'h02;
      `CODE_3:   decode_sym = 6'h03;
      `CODE_4:   decode_sym = 6'h04;
      `CODE_5:   decode_sym = 6'h05;
      `CODE_6:   decode_sym = 6'h06;
      `CODE_7:   decode_sym = 6'h07;
      `CODE_8:   decode_sym = 6'h08;
      `CODE_9:   decode_sym = 6'h09;
      `CODE_10:  decode_sym = 6'h0a;
      `CODE_11:  decode_sym = 6'h0b;
      `CODE_12:  decode_sym = 6'h0c;
      `CODE_13:  decode_sym = 6'h0d;
      `CODE_14:  decode_sym = 6'h0e;
      `CODE_15:  decode_sym = 6'h0f;
      `CODE_EOP: decode_sym = 6'h10;
      default:   decode_sym = 6'h20;  // no valid code word
    endcase
  endfunction

  assign dec    = decode_sym(sl_data ^ last_data);  // NRZ, changed wires only
  assign sl_ack = ack_tgl;

  // sample on the falling edge, sl_data moves on the rising one
  always @(negedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      last_data <= '0;
      pend      <= 1'b0;
      wait_cnt  <= '0;
      ack_tgl   <= 1'b0;
      rx_buf    <= '0;
      nib_idx   <= 0;
      rx_pkt    <= '0;
      rx_nsyms  <= 0;
      rx_count  <= 0;
      rx_bad    <= 1'b0;
    end else if (sl_data != last_data) begin
      last_data <= sl_data;
      pend      <= 1'b1;
      wait_cnt  <= ack_delay;
      if (dec[5] || pend) begin
        rx_bad <= 1'b1;  // bad code, or new symbol before its ack
      end
      if (dec[4]) begin
        rx_pkt   <= rx_buf;  // eop closes the packet
        rx_nsyms <= nib_idx;
        rx_count <= rx_count + 1;
        rx_buf   <= '0;
        nib_idx  <= 0;
      end else if (nib_idx < `LONG_SYMS) begin
        rx_buf[nib_idx*4 +: 4] <= dec[3:0];  // lsn first
        nib_idx <= nib_idx + 1;
      end else begin
        rx_bad <= 1'b1;  // too many nibbles
      end
    end else if (pend) begin
      if (wait_cnt == '0) begin
        ack_tgl <= ~ack_tgl;
        pend    <= 1'b0;
      end else begin
        wait_cnt <= wait_cnt - 4'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_spinn_link_sender.sv
`timescale 1ns/100ps
`default_nettype none

`include "spinn_link_consts.svh"

module tb_spinn_link_sender
  import spinn_link_pkg::*;
();

  localparam int N_ROWS      = 12;
  localparam int MAX_DELAY   = 12;  // largest ack delay in the table
  localparam int WATCHDOG_NS = N_ROWS * 19 * (MAX_DELAY + 8) * 10 + 8 * 10;

  typedef struct packed {
    logic       is_long;
    logic [3:0] delay;     // receiver ack delay, cycles
    logic [3:0] gap;       // idle cycles before pkt_vld
    logic       rnd;       // payload drawn from $random
    pkt_t       payload;
    logic [4:0] exp_syms;  // nibbles expected at the far end
  } row_t;

  logic       CLK_IN;
  logic       RESET_IN;
  pkt_t       pkt_data;
  logic       pkt_vld;
  logic       pkt_rdy;
  link_data_t sl_data;
  logic       sl_ack;

  logic [3:0] rx_delay;
  pkt_t       rx_pkt;
  int         rx_nsyms;
  int         rx_count;
  logic       rx_bad;

  row_t       rows [N_ROWS];
  pkt_t       exp_q [$];   // accepted, not yet decoded
  logic [4:0] len_q [$];
  int         seed = 32'h5f21_7ecd;
  int         fail_cnt = 0;
  int         n_done = 0;
  pkt_t       pkt;
  pkt_t       exp_pkt;
  pkt_t       exp_mask;
  logic [4:0] exp_len;
  link_data_t end_wires;   // wire state after the last eop

  spinn_link_sender dut0 (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .sl_data  (sl_data),
    .sl_ack   (sl_ack)
  );

  tb_link_receiver rcv0 (
    .CLK_IN    (CLK_IN),
    .RESET_IN  (RESET_IN),
    .sl_data   (sl_data),
    .ack_delay (rx_delay),
    .sl_ack    (sl_ack),
    .rx_pkt    (rx_pkt),
    .rx_nsyms  (rx_nsyms),
    .rx_count  (rx_count),
    .rx_bad    (rx_bad)
  );

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  task automatic check_val(input string sig, input pkt_t got, input pkt_t exp);
    if (got !== exp) begin
      fail_cnt++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, sig, got, exp);
      $display("TEST FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic report_error(input string why);
    fail_cnt++;
    $display("ERROR: %s", why);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  function automatic row_t make_row(input logic lng, input int dly, input int gap,
                                    input logic rnd, input pkt_t pay, input int syms);
    row_t r;
    r.is_long  = lng;
    r.delay    = 4'(dly);
    r.gap      = 4'(gap);
    r.rnd      = rnd;
    r.payload  = pay;
    r.exp_syms = 5'(syms);
    return r;
  endfunction

  function automatic pkt_t rand_payload();
    logic [95:0] r;
    r = {$random(seed), $random(seed), $random(seed)};
    return r[`PKT_BITS-1:0];
  endfunction

  // long flag, ack delay, gap, random, payload, expected nibbles
  task automatic fill_table();
    rows[0]  = make_row(1'b0,  0, 0, 1'b0, 72'h00_0000_0098_7654_3210, 10);
    rows[1]  = make_row(1'b1,  0, 3, 1'b0, 72'hfe_dcba_9876_5432_10a2, 18);
    rows[2]  = make_row(1'b0, 12, 0, 1'b0, 72'h00_0000_00c5_a3f1_e7b4, 10);  // slow acks
    rows[3]  = make_row(1'b1, 12, 2, 1'b1, '0, 18);
    rows[4]  = make_row(1'b0,  7, 0, 1'b1, '0, 10);
    rows[5]  = make_row(1'b1,  3, 0, 1'b1, '0, 18);  // back to back from here
    rows[6]  = make_row(1'b0,  0, 0, 1'b1, '0, 10);
    rows[7]  = make_row(1'b0,  1, 0, 1'b1, '0, 10);
    rows[8]  = make_row(1'b1,  0, 0, 1'b1, '0, 18);
    rows[9]  = make_row(1'b1,  5, 1, 1'b1, '0, 18);
    rows[10] = make_row(1'b0,  2, 0, 1'b1, '0, 10);
    rows[11] = make_row(1'b1,  9, 0, 1'b1, '0, 18);
  endtask

  // --------------------------------------------------------------------------
  // clock, watchdog
  // --------------------------------------------------------------------------
  initial begin
    CLK_IN = 1'b0;
    forever #5 CLK_IN = ~CLK_IN;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: run hung, not finished after %0d ns", WATCHDOG_NS);
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

  // decoded packets against the accepted ones, in order
  always @(posedge CLK_IN) begin
    if (!RESET_IN && (rx_count != n_done)) begin
      if (exp_q.size() == 0) begin
        report_error("receiver decoded a packet that was never accepted");
      end else begin
        exp_pkt  = exp_q.pop_front();
        exp_len  = len_q.pop_front();
        exp_mask = ~({`PKT_BITS{1'b1}} << (exp_len * 4));  // nibbles actually sent
        check_val("rx_nsyms", pkt_t'(rx_nsyms), pkt_t'(exp_len));
        check_val("rx_pkt", rx_pkt, exp_pkt & exp_mask);
        check_val("rx_bad", pkt_t'(rx_bad), '0);
        n_done++;
      end
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial begin
    RESET_IN = 1'b1;
    pkt_data = '0;
    pkt_vld  = 1'b0;
    rx_delay = '0;
    fill_table();
    repeat (8) @(posedge CLK_IN);
    #1;
    check_val("pkt_rdy", pkt_t'(pkt_rdy), '0);  // still in reset
    check_val("sl_data", pkt_t'(sl_data), '0);
    RESET_IN = 1'b0;
    @(posedge CLK_IN);
    #1;
    check_val("pkt_rdy", pkt_t'(pkt_rdy), pkt_t'(1));

    for (int i = 0; i < N_ROWS; i++) begin
      pkt_vld = 1'b0;
      repeat (int'(rows[i].gap)) begin
        @(posedge CLK_IN);
        #1;
      end
      pkt = rows[i].rnd ? rand_payload() : rows[i].payload;
      pkt[`LONG_FLAG_BIT] = rows[i].is_long;
      rx_delay = rows[i].delay;
      pkt_data = pkt;
      pkt_vld  = 1'b1;
      while (!pkt_rdy) begin   // registered, so this is its value at the next edge
        @(posedge CLK_IN);
        #1;
      end
      // at most one packet still in flight when a new one goes in
      check_val("in_flight_ok", pkt_t'(exp_q.size() <= 1), pkt_t'(1));
      exp_q.push_back(pkt);
      len_q.push_back(rows[i].exp_syms);
      @(posedge CLK_IN);
      #1;
      check_val("pkt_rdy", pkt_t'(pkt_rdy), '0);  // closes after a transfer
    end
    pkt_vld = 1'b0;

    while (exp_q.size() != 0) begin
      @(posedge CLK_IN);
      #1;
    end
    end_wires = sl_data;
    repeat (2 * (MAX_DELAY + 8)) begin
      @(posedge CLK_IN);
    end
    #1;
    check_val("sl_data", pkt_t'(sl_data), pkt_t'(end_wires));  // no symbol after last eop
    check_val("pkt_rdy", pkt_t'(pkt_rdy), pkt_t'(1));          // idle and open again
    check_val("rx_bad", pkt_t'(rx_bad), '0);

    if (fail_cnt == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("TEST FAIL");
      $fatal(1, "errors seen");
    end
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
spinn_link_pkg.sv
nrz_2of7_encoder.sv
pkt_serializer.sv
flit_link_tx.sv
spinn_link_sender.sv
spinn_link_sva.sv
tb_link_receiver.sv
tb_spinn_link_sender.sv

//--- run_sim.sh
#!/bin/sh
# compile the testbench with Verilator, run it, search the output for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_spinn_link_sender -Mdir obj_dir -o sim_tb \
  || { echo "run_sim: verilator build failed"; exit 1; }

sim_out=$(./obj_dir/sim_tb 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -qx "TEST PASS" \
  && echo "run_sim: passed" \
  || { echo "run_sim: failed"; exit 1; }
